//--- bench/controlVectors.svh
`ifndef CONTROL_VECTORS_SVH
`define CONTROL_VECTORS_SVH

// columns: op, funct, cycles fetch to fetch, aluSel in the first execute state,
// regWrite, memWrite and pcLoad cycles after fetchDelay2, memToReg at the write
typedef struct {
	opcode_t op;
	funct_t funct;
	logic aluZero;	// drawn at random for branch rows
	int cycles;	// 0 marks break, which never returns
	aluOp_t aluSel;
	int regWrites;
	int memWrites;
	int pcLoads;
	logic [1:0] memToReg;
} vector_t;

vector_t vectors[$];

task automatic addVector(input opcode_t rowOp, input funct_t rowFunct, input int cycles,
	input aluOp_t rowAluSel, input int regWrites, input int memWrites, input int pcLoads,
	input logic [1:0] rowMemToReg);
	vector_t row;
	row.op = rowOp;
	row.funct = rowFunct;
	row.aluZero = 1'b0;
	row.cycles = cycles;
	row.aluSel = rowAluSel;
	row.regWrites = regWrites;
	row.memWrites = memWrites;
	row.pcLoads = pcLoads;
	row.memToReg = rowMemToReg;
	vectors.push_back(row);
endtask

task automatic buildTable;
	addVector(opFunct, functAdd, 6, aluAdd, 1, 0, 0, MemToRegAlu);
	addVector(opFunct, functSub, 6, aluSub, 1, 0, 0, MemToRegAlu);
	addVector(opFunct, functAnd, 6, aluAnd, 1, 0, 0, MemToRegAlu);
	addVector(opFunct, functXor, 6, aluXor, 1, 0, 0, MemToRegAlu);
	addVector(opFunct, functNop, 5, aluNone, 0, 0, 0, MemToRegAlu);
	addVector(opBeq, functNop, 5, aluSub, 0, 0, 0, MemToRegAlu);	// pcLoads set from aluZero
	addVector(opBeq, functAdd, 5, aluSub, 0, 0, 0, MemToRegAlu);
	addVector(opBne, functNop, 5, aluSub, 0, 0, 0, MemToRegAlu);
	addVector(opBne, functXor, 5, aluSub, 0, 0, 0, MemToRegAlu);
	addVector(opJ, functNop, 5, aluAdd, 0, 0, 1, MemToRegAlu);
	addVector(opLui, functNop, 5, aluNone, 1, 0, 0, MemToRegImm);
	addVector(opLw, functNop, 9, aluAdd, 1, 0, 0, MemToRegMdr);
	addVector(opSw, functNop, 7, aluAdd, 0, 2, 0, MemToRegAlu);
	addVector(opcode_t'(6'h3f), functNop, 5, aluNone, 0, 0, 0, MemToRegAlu);	// unlisted opcode
	addVector(opFunct, funct_t'(6'h3e), 5, aluNone, 0, 0, 0, MemToRegAlu);	// unlisted funct
	addVector(opFunct, functBreak, 0, aluNone, 0, 0, 0, MemToRegAlu);	// stays last
endtask

`endif

//--- bench/controlTb.sv
`timescale 1ns/1ns

module controlTb;

	import controlPkg::*;

	`include "controlVectors.svh"

	logic Clk;
	logic reset;
	logic aluZero;
	opcode_t op;
	funct_t funct;
	controlState_t stateOut;
	logic pcWrite, pcWriteCond, pcLoad, memWrite, irWrite, regWrite, regReset, regDst;
	logic aluSrcA, iOrD, aLoad, aReset, bLoad, bReset, mdrLoad, mdrReset;
	logic aluOutLoad, aluOutReset, irReset;
	aluOp_t aluSel;
	logic [1:0] memToReg, pcSource, aluSrcB;
	logic [5:0] resetStrobes;
	logic [9:0] writeStrobes;
	logic [18:0] allStrobes;
	logic tableReady;
	int errorCount;
	vector_t current;	// row being executed

	mipsControl i_dut (.*);

	assign resetStrobes = {regReset, aReset, bReset, mdrReset, aluOutReset, irReset};
	assign writeStrobes = {pcWrite, pcWriteCond, pcLoad, memWrite, irWrite, regWrite,
		aLoad, bLoad, mdrLoad, aluOutLoad};
	assign allStrobes = {writeStrobes, resetStrobes, regDst, aluSrcA, iOrD};

	always #10 Clk = ~Clk;

	function automatic controlState_t fetchState(input int cycle);
		case (cycle)
			0: return stateFetch;
			1: return stateFetchDelay1;
			2: return stateFetchDelay2;
			default: return stateDecode;
		endcase
	endfunction

	task automatic reportValue(input string name, input int expected, input int actual);
		$display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic driveInputs;
		logic [5:0] fillOp;
		logic [5:0] fillFunct;
		fillOp = $urandom;
		fillFunct = $urandom;
		op = (stateOut == stateDecode) ? current.op : opcode_t'(fillOp);	// held in decode only
		funct = (stateOut == stateDecode) ? current.funct : funct_t'(fillFunct);
		aluZero = current.aluZero;
	endtask

	task automatic advanceCycle;
		@(posedge Clk);
		#2;
		driveInputs();
		@(negedge Clk);	// outputs settled here
	endtask

	task automatic applyReset;
		reset = 1'b1;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge Clk);
			#2;
			if (i == 15) reset = 1'b0;	// last check is the cycle after release
			driveInputs();
			@(negedge Clk);
			if (stateOut !== stateReset) reportValue("stateOut", stateReset, stateOut);
			if (resetStrobes !== 6'h3f) reportValue("reset strobes", 6'h3f, resetStrobes);
			if (writeStrobes !== 10'h0) reportValue("write strobes", 0, writeStrobes);
		end
		advanceCycle();
		if (stateOut !== stateFetch) reportValue("stateOut", stateFetch, stateOut);
		if (irWrite !== 1'b1) reportValue("irWrite", 1, irWrite);
		if (mdrLoad !== 1'b1) reportValue("mdrLoad", 1, mdrLoad);
	endtask

	task automatic runInstruction;
		int cycle;
		int regWrites;
		int memWrites;
		int pcLoads;
		int mdrRun;
		int mdrLongest;
		bit done;
		cycle = 0;
		regWrites = 0;
		memWrites = 0;
		pcLoads = 0;
		mdrRun = 0;
		mdrLongest = 0;
		done = 1'b0;
		while (!done)
		begin
			if (cycle < 4)
			begin
				if (stateOut !== fetchState(cycle)) reportValue("stateOut", fetchState(cycle), stateOut);
				if (pcWrite !== (cycle == 2)) reportValue("pcWrite", cycle == 2, pcWrite);
				if (pcLoad !== (cycle == 2)) reportValue("pcLoad", cycle == 2, pcLoad);
				if (cycle == 2 && aluSel !== aluAdd) reportValue("aluSel", aluAdd, aluSel);
				if (cycle == 2 && aluSrcB !== SrcBFour) reportValue("aluSrcB", SrcBFour, aluSrcB);
				if (cycle == 2 && pcSource !== PcSrcAlu) reportValue("pcSource", PcSrcAlu, pcSource);
			end
			else
			begin
				if (cycle == 4 && aluSel !== current.aluSel) reportValue("aluSel", current.aluSel, aluSel);
				// R-type rows write the ALU result back
				if (cycle == 4 && current.regWrites == 1 && current.memToReg == MemToRegAlu
					&& aluOutLoad !== 1'b1) reportValue("aluOutLoad", 1, aluOutLoad);
				if (regWrite === 1'b1)
				begin
					regWrites++;
					if (memToReg !== current.memToReg) reportValue("memToReg", current.memToReg, memToReg);
					if (regDst !== (current.memToReg == MemToRegAlu)) reportValue("regDst",
						current.memToReg == MemToRegAlu, regDst);
				end
				if (memWrite === 1'b1)
				begin
					memWrites++;
					if (iOrD !== 1'b1) reportValue("iOrD", 1, iOrD);
				end
				if (pcLoad === 1'b1)
				begin
					pcLoads++;
					if (pcSource !== ((current.op == opJ) ? PcSrcJump : PcSrcAluOut)) reportValue(
						"pcSource", (current.op == opJ) ? PcSrcJump : PcSrcAluOut, pcSource);
				end
				mdrRun = (mdrLoad === 1'b1 && iOrD === 1'b1) ? mdrRun + 1 : 0;
				if (mdrRun > mdrLongest) mdrLongest = mdrRun;
			end
			advanceCycle();
			cycle++;
			if (stateOut === stateFetch) done = 1'b1;
			else if (cycle > 16)
			begin
				$display("Error at %0t ns: instruction did not return to fetch", $time);
				errorCount++;
				done = 1'b1;
			end
		end
		if (cycle != current.cycles) reportValue("cycle count", current.cycles, cycle);
		if (regWrites != current.regWrites) reportValue("regWrite count", current.regWrites, regWrites);
		if (memWrites != current.memWrites) reportValue("memWrite count", current.memWrites, memWrites);
		if (pcLoads != current.pcLoads) reportValue("pcLoad count", current.pcLoads, pcLoads);
		if (mdrLongest != ((current.op == opLw) ? 3 : 0)) reportValue("mdrLoad run",
			(current.op == opLw) ? 3 : 0, mdrLongest);
	endtask

	task automatic runBreak;
		for (int cycle = 0; cycle < 4; cycle++)
		begin
			if (stateOut !== fetchState(cycle)) reportValue("stateOut", fetchState(cycle), stateOut);
			advanceCycle();
		end
		for (int cycle = 0; cycle < 20; cycle++)
		begin
			if (stateOut !== stateBreak) reportValue("stateOut", stateBreak, stateOut);
			if (allStrobes !== 19'h0) reportValue("strobes", 0, allStrobes);
			if (aluSel !== aluNone) reportValue("aluSel", aluNone, aluSel);
			advanceCycle();
		end
		@(posedge Clk);
		#2;
		applyReset();	// only way out of break
	endtask

	initial
	begin
		Clk = 1'b0;
		reset = 1'b1;
		aluZero = 1'b0;
		op = opFunct;
		funct = functNop;
		errorCount = 0;
		tableReady = 1'b0;
		void'($urandom(32'h4f40_feeb));
		buildTable();
		foreach (vectors[i])
		begin
			if (vectors[i].op == opBeq || vectors[i].op == opBne)
			begin
				// a repeated branch row takes the other zero flag
				if (i > 0 && vectors[i - 1].op == vectors[i].op)
					vectors[i].aluZero = !vectors[i - 1].aluZero;
				else
					vectors[i].aluZero = $urandom % 2;
				// beq loads the pc on zero, bne on nonzero
				vectors[i].pcLoads = (vectors[i].op == opBeq) ? vectors[i].aluZero : !vectors[i].aluZero;
			end
		end
		tableReady = 1'b1;
		current = vectors[0];
		applyReset();
		foreach (vectors[i])
		begin
			current = vectors[i];
			if (current.cycles == 0) runBreak();
			else runInstruction();
		end
		$display("%0d errors in %0d instruction rows", errorCount, vectors.size());
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int limitCycles;
		wait (tableReady === 1'b1);
		limitCycles = vectors.size() * 12 + 60;
		#(limitCycles * 20);
		$display("Timeout: the run did not finish within %0d clock cycles", limitCycles);
		$display("%0d errors before the timeout", errorCount);
		$display("TEST FAILED");
		$finish;
	end

endmodule : controlTb

//--- build.f
+incdir+bench
hw/controlPkg.sv
hw/opcodeDecoder.sv
hw/stateSequencer.sv
hw/controlSignalDecoder.sv
hw/mipsControl.sv
bench/controlTb.sv

//--- hw/controlPkg.sv
package controlPkg;

	// instruction field widths
	localparam int OpWidth = 6;
	localparam int FunctWidth = 6;

	// primary opcode field, bits 31:26 of the instruction
	typedef enum logic [OpWidth-1:0] {
		opFunct = 6'h00,	// R-type, look at funct
		opJ = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_t;

	// function field of R-type instructions, bits 5:0
	typedef enum logic [FunctWidth-1:0] {
		functNop = 6'h00,
		functBreak = 6'h0d,
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functXor = 6'h26
	} funct_t;

	typedef enum logic [4:0] {
		stateReset,
		stateFetch,
		stateFetchDelay1,	// instruction memory latency
		stateFetchDelay2,	// pc + 4 written here
		stateDecode,
		stateAdd,
		stateAnd,
		stateSub,
		stateXor,
		stateRWait,	// R-type register write-back
		stateNop,
		stateBreak,	// held until reset
		stateBeq,
		stateBne,
		stateJump,
		stateLui,
		stateLwAddressComp,
		stateLw,
		stateLwDelay1,
		stateLwDelay2,
		stateWriteBack,
		stateSwAddressComp,
		stateSw,
		stateSwDelay
	} controlState_t;

	// operation select seen by the ALU
	typedef enum logic [2:0] {
		aluNone = 3'b000,
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluXor = 3'b110
	} aluOp_t;

	// register file write data mux
	localparam logic [1:0] MemToRegAlu = 2'b00;	// aluOut register
	localparam logic [1:0] MemToRegMdr = 2'b01;	// loaded word
	localparam logic [1:0] MemToRegImm = 2'b10;	// upper immediate

	// next pc mux
	localparam logic [1:0] PcSrcAlu = 2'b00;	// alu result, pc + 4
	localparam logic [1:0] PcSrcAluOut = 2'b01;	// branch target held in aluOut
	localparam logic [1:0] PcSrcJump = 2'b10;	// pc upper bits and target field

	// second alu operand mux
	localparam logic [1:0] SrcBReg = 2'b00;	// B register
	localparam logic [1:0] SrcBFour = 2'b01;	// constant 4
	localparam logic [1:0] SrcBImm = 2'b10;	// sign extended offset
	localparam logic [1:0] SrcBImmShift = 2'b11;	// offset times 4

endpackage : controlPkg

//--- hw/controlSignalDecoder.sv
`timescale 1ns/1ns

module controlSignalDecoder (
	input controlPkg::controlState_t state,
	input logic aluZero,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic pcLoad,
	output logic memWrite,
	output logic irWrite,
	output logic regWrite,
	output logic regReset,
	output logic regDst,
	output logic aluSrcA,
	output logic iOrD,
	output logic aLoad,
	output logic aReset,
	output logic bLoad,
	output logic bReset,
	output logic mdrLoad,
	output logic mdrReset,
	output logic aluOutLoad,
	output logic aluOutReset,
	output logic irReset,
	output controlPkg::aluOp_t aluSel,
	output logic [1:0] memToReg,
	output logic [1:0] pcSource,
	output logic [1:0] aluSrcB
);

	import controlPkg::*;

	logic branchTaken;

	always_comb
	begin
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		memWrite = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		regReset = 1'b0;
		regDst = 1'b0;
		aluSrcA = 1'b0;	// pc
		iOrD = 1'b0;	// instruction address
		aLoad = 1'b0;
		aReset = 1'b0;
		bLoad = 1'b0;
		bReset = 1'b0;
		mdrLoad = 1'b0;
		mdrReset = 1'b0;
		aluOutLoad = 1'b0;
		aluOutReset = 1'b0;
		irReset = 1'b0;
		aluSel = aluNone;
		memToReg = MemToRegAlu;
		pcSource = PcSrcAlu;
		aluSrcB = SrcBReg;

		case (state)
			stateReset:
			begin
				regReset = 1'b1;	// clear every datapath register
				aReset = 1'b1;
				bReset = 1'b1;
				mdrReset = 1'b1;
				aluOutReset = 1'b1;
				irReset = 1'b1;
			end

			stateFetch,
			stateFetchDelay1:
			begin
				irWrite = 1'b1;	// hold the memory read
				mdrLoad = 1'b1;
				aluSrcB = SrcBFour;
			end

			stateFetchDelay2:
			begin
				irWrite = 1'b1;
				mdrLoad = 1'b1;
				pcWrite = 1'b1;	// pc + 4
				aluSel = aluAdd;
				aluSrcB = SrcBFour;
				pcSource = PcSrcAlu;
			end

			stateDecode:
			begin
				aLoad = 1'b1;	// rs into A
				bLoad = 1'b1;	// rt into B
				aluSel = aluAdd;	// branch target ahead of time
				aluSrcB = SrcBImmShift;
				aluOutLoad = 1'b1;
			end

			stateAdd,
			stateAnd,
			stateSub,
			stateXor:
			begin
				aluSrcA = 1'b1;
				aluSrcB = SrcBReg;
				aluOutLoad = 1'b1;
				case (state)
					stateAnd: aluSel = aluAnd;
					stateSub: aluSel = aluSub;
					stateXor: aluSel = aluXor;
					default: aluSel = aluAdd;
				endcase
			end

			stateRWait:
			begin
				regWrite = 1'b1;
				regDst = 1'b1;	// rd field
				memToReg = MemToRegAlu;
			end

			stateJump:
			begin
				pcWrite = 1'b1;
				pcSource = PcSrcJump;
				aluSel = aluAdd;
				aluSrcB = SrcBImmShift;
				iOrD = 1'b1;
				aluOutLoad = 1'b1;
			end

			stateBeq,
			stateBne:
			begin
				pcWriteCond = 1'b1;	// qualified by aluZero below
				aluSel = aluSub;	// compare A and B
				aluSrcA = 1'b1;
				aluSrcB = SrcBReg;
				pcSource = PcSrcAluOut;
			end

			stateLui:
			begin
				regWrite = 1'b1;	// rt gets the upper immediate
				memToReg = MemToRegImm;
			end

			stateLwAddressComp,
			stateSwAddressComp:
			begin
				aluSel = aluAdd;	// A plus offset
				aluSrcA = 1'b1;
				aluSrcB = SrcBImm;
				aluOutLoad = 1'b1;
			end

			stateSw,
			stateSwDelay:
			begin
				memWrite = 1'b1;
				iOrD = 1'b1;	// data address
			end

			stateLw,
			stateLwDelay1,
			stateLwDelay2:
			begin
				iOrD = 1'b1;
				mdrLoad = 1'b1;	// capture the word
			end

			stateWriteBack:
			begin
				regWrite = 1'b1;	// rt, regDst stays low
				memToReg = MemToRegMdr;
			end

			default:
			begin
				aluSel = aluNone;	// nop, break
			end
		endcase
	end

	// bne takes the branch on a nonzero difference
	assign branchTaken = (state == stateBne) ? ~aluZero : aluZero;
	assign pcLoad = pcWrite | (pcWriteCond & branchTaken);

endmodule : controlSignalDecoder

//--- hw/mipsControl.sv
`timescale 1ns/1ns

module mipsControl (
	input logic Clk,
	input logic reset,
	input logic aluZero,
	input controlPkg::opcode_t op,
	input controlPkg::funct_t funct,
	output controlPkg::controlState_t stateOut,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic pcLoad,
	output logic memWrite,
	output logic irWrite,
	output logic regWrite,
	output logic regReset,
	output logic regDst,
	output logic aluSrcA,
	output logic iOrD,
	output logic aLoad,
	output logic aReset,
	output logic bLoad,
	output logic bReset,
	output logic mdrLoad,
	output logic mdrReset,
	output logic aluOutLoad,
	output logic aluOutReset,
	output logic irReset,
	output controlPkg::aluOp_t aluSel,
	output logic [1:0] memToReg,
	output logic [1:0] pcSource,
	output logic [1:0] aluSrcB
);

	import controlPkg::*;

	controlState_t dispatchState;	// first state after decode

	opcodeDecoder i_opcodeDecoder (
		.op(op),
		.funct(funct),
		.dispatchState(dispatchState)
	);

	stateSequencer i_stateSequencer (
		.Clk(Clk),
		.reset(reset),
		.dispatchState(dispatchState),
		.state(stateOut)	// also the outward state view
	);

	controlSignalDecoder i_controlSignalDecoder (
		.state(stateOut),
		.aluZero(aluZero),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.pcLoad(pcLoad),
		.memWrite(memWrite),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.regReset(regReset),
		.regDst(regDst),
		.aluSrcA(aluSrcA),
		.iOrD(iOrD),
		.aLoad(aLoad),
		.aReset(aReset),
		.bLoad(bLoad),
		.bReset(bReset),
		.mdrLoad(mdrLoad),
		.mdrReset(mdrReset),
		.aluOutLoad(aluOutLoad),
		.aluOutReset(aluOutReset),
		.irReset(irReset),
		.aluSel(aluSel),
		.memToReg(memToReg),
		.pcSource(pcSource),
		.aluSrcB(aluSrcB)
	);

endmodule : mipsControl

//--- hw/opcodeDecoder.sv
`timescale 1ns/1ns

module opcodeDecoder (
	input controlPkg::opcode_t op,
	input controlPkg::funct_t funct,
	output controlPkg::controlState_t dispatchState
);

	import controlPkg::*;

	always_comb
	begin
		case (op)
			opFunct:
			begin
				case (funct)
					functAdd: dispatchState = stateAdd;
					functAnd: dispatchState = stateAnd;
					functSub: dispatchState = stateSub;
					functXor: dispatchState = stateXor;
					functBreak: dispatchState = stateBreak;
					functNop: dispatchState = stateNop;
					// unrecognised funct idles one cycle, then back to fetch
					default: dispatchState = stateNop;
				endcase
			end

			opBeq:
			begin
				dispatchState = stateBeq;
			end

			opBne:
			begin
				dispatchState = stateBne;
			end

			opLw:
			begin
				dispatchState = stateLwAddressComp;	// address first
			end

			opSw:
			begin
				dispatchState = stateSwAddressComp;
			end

			opLui:
			begin
				dispatchState = stateLui;
			end

			opJ:
			begin
				dispatchState = stateJump;
			end

			default:
			begin
				dispatchState = stateNop;	// unknown opcode, no strobes, then fetch
			end
		endcase
	end

endmodule : opcodeDecoder

//--- hw/stateSequencer.sv
`timescale 1ns/1ns

module stateSequencer (
	input logic Clk,
	input logic reset,
	input controlPkg::controlState_t dispatchState,
	output controlPkg::controlState_t state
);

	import controlPkg::*;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= stateReset;
		end
		else
		begin
			case (state)
				stateReset: state <= stateFetch;

				// fixed fetch chain
				stateFetch: state <= stateFetchDelay1;
				stateFetchDelay1: state <= stateFetchDelay2;
				stateFetchDelay2: state <= stateDecode;
				stateDecode: state <= dispatchState;	// op and funct sampled here

				stateAdd,
				stateAnd,
				stateSub,
				stateXor:
				begin
					state <= stateRWait;
				end

				stateRWait: state <= stateFetch;

				// load chain
				stateLwAddressComp: state <= stateLw;
				stateLw: state <= stateLwDelay1;
				stateLwDelay1: state <= stateLwDelay2;
				stateLwDelay2: state <= stateWriteBack;
				stateWriteBack: state <= stateFetch;

				// store chain
				stateSwAddressComp: state <= stateSw;
				stateSw: state <= stateSwDelay;
				stateSwDelay: state <= stateFetch;

				stateBreak: state <= stateBreak;	// only reset gets out

				stateNop,
				stateBeq,
				stateBne,
				stateJump,
				stateLui:
				begin
					state <= stateFetch;
				end

				default:
				begin
					state <= stateFetch;
				end
			endcase
		end
	end

endmodule : stateSequencer
